// File: build.f
source/issue_pkg.sv
source/reg_usage_decode.sv
source/cond_eval.sv
source/hazard_scoreboard.sv
source/issue_stage.sv
verification/issue_stage_checker.sv
verification/issue_stage_tb.sv

// File: source/cond_eval.sv
`timescale 1ns/1ps

module cond_eval (
	input  issue_pkg::cond_e cond,
	input  logic [3:0]       flags,
	output logic             condition_met
);

	logic n;
	logic z;
	logic c;
	logic v;

	// flags arrives as the CPSR slice from n down to v.
	assign n = flags[issue_pkg::cpsr_n - issue_pkg::cpsr_v];
	assign z = flags[issue_pkg::cpsr_z - issue_pkg::cpsr_v];
	assign c = flags[issue_pkg::cpsr_c - issue_pkg::cpsr_v];
	assign v = flags[0];

	always_comb
	begin
		condition_met = 1'b0;
		case (cond)
		issue_pkg::cond_eq: condition_met = z;
		issue_pkg::cond_ne: condition_met = !z;
		issue_pkg::cond_cs: condition_met = c;
		issue_pkg::cond_cc: condition_met = !c;
		issue_pkg::cond_mi: condition_met = n;
		issue_pkg::cond_pl: condition_met = !n;
		issue_pkg::cond_vs: condition_met = v;
		issue_pkg::cond_vc: condition_met = !v;
		issue_pkg::cond_hi: condition_met = c && !z;
		issue_pkg::cond_ls: condition_met = !c || z;
		issue_pkg::cond_ge: condition_met = (n == v);
		issue_pkg::cond_lt: condition_met = (n != v);
		issue_pkg::cond_gt: condition_met = !z && (n == v);
		issue_pkg::cond_le: condition_met = z || (n != v);
		issue_pkg::cond_al: condition_met = 1'b1;
		// nv never executes.
		issue_pkg::cond_nv: condition_met = 1'b0;
		default:            condition_met = 1'b0;
		endcase
	end

endmodule

// File: source/hazard_scoreboard.sv
`timescale 1ns/1ps

module hazard_scoreboard (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        flush,
	input  logic        advance,
	input  logic [15:0] issue_def_regs,
	input  logic        issue_def_cpsr,
	input  logic [15:0] use_regs,
	input  logic        use_cpsr,
	output logic        waiting
);

	// slot 0 is the execute stage and the last slot is memory.
	// once a write reaches writeback the register file has it, so it drops out.
	logic [15:0] regs_inflight [issue_pkg::inflight_slots];
	logic        cpsr_inflight [issue_pkg::inflight_slots];

	logic [15:0] regs_busy;
	logic        cpsr_busy;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < issue_pkg::inflight_slots; i++)
			begin
				regs_inflight[i] <= 16'h0;
				cpsr_inflight[i] <= 1'b0;
			end
		end
		else if (flush)
		begin
			// a flush empties both slots and wins over stall.
			for (int i = 0; i < issue_pkg::inflight_slots; i++)
			begin
				regs_inflight[i] <= 16'h0;
				cpsr_inflight[i] <= 1'b0;
			end
		end
		else if (advance)
		begin
			regs_inflight[0] <= issue_def_regs;
			cpsr_inflight[0] <= issue_def_cpsr;
			for (int i = 1; i < issue_pkg::inflight_slots; i++)
			begin
				regs_inflight[i] <= regs_inflight[i-1];
				cpsr_inflight[i] <= cpsr_inflight[i-1];
			end
		end
	end

	always_comb
	begin
		regs_busy = 16'h0;
		cpsr_busy = 1'b0;
		for (int i = 0; i < issue_pkg::inflight_slots; i++)
		begin
			regs_busy = regs_busy | regs_inflight[i];
			cpsr_busy = cpsr_busy | cpsr_inflight[i];
		end
	end

	assign waiting = (|(use_regs & regs_busy)) || (use_cpsr && cpsr_busy);

endmodule

// File: source/issue_pkg.sv
package issue_pkg;

	// encoding groups, listed in the order the decoder has to try them.
	// multiply sits inside the ALU space, so it must be matched first.
	typedef enum logic [4:0] {
		class_mult,
		class_mrs,
		class_msr,
		class_msr_flags,
		class_swp,
		class_bx,
		class_hdata_reg,
		class_hdata_imm,
		class_alu,
		class_ldrstr_undef,
		class_ldrstr,
		class_ldmstm,
		class_branch,
		class_ldcstc,
		class_cdp,
		class_mrcmcr,
		class_swi,
		class_unknown
	} insn_class_e;

	// condition field, bits 31:28 of every instruction.
	typedef enum logic [3:0] {
		cond_eq,
		cond_ne,
		cond_cs,
		cond_cc,
		cond_mi,
		cond_pl,
		cond_vs,
		cond_vc,
		cond_hi,
		cond_ls,
		cond_ge,
		cond_lt,
		cond_gt,
		cond_le,
		cond_al,
		cond_nv
	} cond_e;

	// data-processing opcode, bits 24:21.
	typedef enum logic [3:0] {
		alu_and,
		alu_eor,
		alu_sub,
		alu_rsb,
		alu_add,
		alu_adc,
		alu_sbc,
		alu_rsc,
		alu_tst,
		alu_teq,
		alu_cmp,
		alu_cmn,
		alu_orr,
		alu_mov,
		alu_bic,
		alu_mvn
	} alu_op_e;

	// shift type of a register operand, bits 6:5.
	typedef enum logic [1:0] {
		shift_lsl,
		shift_lsr,
		shift_asr,
		shift_ror
	} shift_e;

	// flag positions in the CPSR word.
	localparam int cpsr_n = 31;
	localparam int cpsr_z = 30;
	localparam int cpsr_c = 29;
	localparam int cpsr_v = 28;

	// the pc is never tracked as a dependency.
	localparam logic [3:0] pc_reg = 4'd15;

	// one slot for execute, one for memory.
	localparam int inflight_slots = 2;

endpackage

// File: source/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        stall,
	input  logic        flush,
	input  logic        inbubble,
	input  logic [31:0] insn,
	input  logic [31:0] inpc,
	input  logic [31:0] cpsr,
	output logic        outstall,
	output logic        outbubble,
	output logic [31:0] outpc,
	output logic [31:0] outinsn
);

	issue_pkg::cond_e insn_cond;

	logic [15:0] use_regs;
	logic [15:0] def_regs;
	logic        use_cpsr;
	logic        def_cpsr;
	logic        condition_met;
	logic        waiting;
	logic        advance;
	logic        issuing;
	logic [15:0] issue_def_regs;
	logic        issue_def_cpsr;

	assign insn_cond = issue_pkg::cond_e'(insn[31:28]);

	reg_usage_decode u_decode (
		.insn     (insn),
		.use_regs (use_regs),
		.use_cpsr (use_cpsr),
		.def_regs (def_regs),
		.def_cpsr (def_cpsr)
	);

	cond_eval u_cond (
		.cond          (insn_cond),
		.flags         (cpsr[issue_pkg::cpsr_n:issue_pkg::cpsr_v]),
		.condition_met (condition_met)
	);

	assign advance = !stall;

	// only a real instruction that leaves this cycle and passes its condition is recorded.
	assign issuing        = !inbubble && !waiting && condition_met;
	assign issue_def_regs = issuing ? def_regs : 16'h0;
	assign issue_def_cpsr = issuing && def_cpsr;

	hazard_scoreboard u_scoreboard (
		.clk            (clk),
		.arst_n         (arst_n),
		.flush          (flush),
		.advance        (advance),
		.issue_def_regs (issue_def_regs),
		.issue_def_cpsr (issue_def_cpsr),
		.use_regs       (use_regs),
		.use_cpsr       (use_cpsr),
		.waiting        (waiting)
	);

	// a bubble never has to wait, so it does not hold up decode.
	assign outstall = stall || (waiting && !inbubble);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			outbubble <= 1'b1;
			outpc     <= 32'h0;
			outinsn   <= 32'h0;
		end
		else if (flush)
			outbubble <= 1'b1;
		else if (advance)
		begin
			outbubble <= inbubble || waiting || !condition_met;
			outpc     <= inpc;
			outinsn   <= insn;
		end
	end

endmodule

// File: source/reg_usage_decode.sv
`timescale 1ns/1ps

module reg_usage_decode (
	input  logic [31:0] insn,
	output logic [15:0] use_regs,
	output logic        use_cpsr,
	output logic [15:0] def_regs,
	output logic        def_cpsr
);

	issue_pkg::insn_class_e insn_class;
	issue_pkg::cond_e       cond;
	issue_pkg::alu_op_e     alu_op;
	issue_pkg::shift_e      shift_type;

	logic [3:0]  rn;
	logic [3:0]  rd;
	logic [3:0]  rs;
	logic [3:0]  rm;
	logic [3:0]  rd_mul;
	logic [3:0]  rn_mul;
	logic [15:0] reg_list;
	logic        cond_matters;
	logic        shift_uses_carry;
	logic        load;
	logic        write_back;

	// one-hot mask of a register, with the pc left out.
	function automatic logic [15:0] idxbit(input logic [3:0] r);
		if (r == issue_pkg::pc_reg)
			return 16'h0;
		return 16'h1 << r;
	endfunction

	assign cond       = issue_pkg::cond_e'(insn[31:28]);
	assign alu_op     = issue_pkg::alu_op_e'(insn[24:21]);
	assign shift_type = issue_pkg::shift_e'(insn[6:5]);

	assign rn     = insn[19:16];
	assign rd     = insn[15:12];
	assign rs     = insn[11:8];
	assign rm     = insn[3:0];
	assign rd_mul = insn[19:16];
	assign rn_mul = insn[15:12];

	assign reg_list = insn[15:0] & ~(16'h1 << issue_pkg::pc_reg);
	assign load     = insn[20];

	// single and halfword transfers write the base back on W or on post-index.
	assign write_back = insn[21] | !insn[24];

	assign cond_matters = (cond != issue_pkg::cond_al);

	// an immediate shift by zero of type lsl or ror (rrx) feeds the carry flag through.
	assign shift_uses_carry = !insn[4] && (insn[11:7] == 5'd0) &&
		((shift_type == issue_pkg::shift_lsl) || (shift_type == issue_pkg::shift_ror));

	always_comb
	begin
		priority casez (insn)
		32'b????_0000_00??_????_????_????_1001_????: insn_class = issue_pkg::class_mult;
		32'b????_0001_0?00_1111_????_0000_0000_0000: insn_class = issue_pkg::class_mrs;
		32'b????_0001_0?10_1001_1111_0000_0000_????: insn_class = issue_pkg::class_msr;
		32'b????_00?1_0?10_1000_1111_????_????_????: insn_class = issue_pkg::class_msr_flags;
		32'b????_0001_0?00_????_????_0000_1001_????: insn_class = issue_pkg::class_swp;
		32'b????_0001_0010_1111_1111_1111_0001_????: insn_class = issue_pkg::class_bx;
		32'b????_000?_?0??_????_????_0000_1??1_????: insn_class = issue_pkg::class_hdata_reg;
		32'b????_000?_?1??_????_????_????_1??1_????: insn_class = issue_pkg::class_hdata_imm;
		32'b????_00??_????_????_????_????_????_????: insn_class = issue_pkg::class_alu;
		32'b????_011?_????_????_????_????_???1_????: insn_class = issue_pkg::class_ldrstr_undef;
		32'b????_01??_????_????_????_????_????_????: insn_class = issue_pkg::class_ldrstr;
		32'b????_100?_????_????_????_????_????_????: insn_class = issue_pkg::class_ldmstm;
		32'b????_101?_????_????_????_????_????_????: insn_class = issue_pkg::class_branch;
		32'b????_110?_????_????_????_????_????_????: insn_class = issue_pkg::class_ldcstc;
		32'b????_1110_????_????_????_????_???0_????: insn_class = issue_pkg::class_cdp;
		32'b????_1110_????_????_????_????_???1_????: insn_class = issue_pkg::class_mrcmcr;
		32'b????_1111_????_????_????_????_????_????: insn_class = issue_pkg::class_swi;
		default:                                     insn_class = issue_pkg::class_unknown;
		endcase
	end

	always_comb
	begin
		use_cpsr = cond_matters;
		use_regs = 16'h0;
		def_cpsr = 1'b0;
		def_regs = 16'h0;
		case (insn_class)
		issue_pkg::class_mult:
		begin
			use_regs = idxbit(rs) | idxbit(rm) | (insn[21] ? idxbit(rn_mul) : 16'h0);
			def_cpsr = insn[20];
			def_regs = idxbit(rd_mul);
		end
		issue_pkg::class_mrs:
		begin
			// bit 22 clear selects the CPSR rather than the SPSR as source.
			use_cpsr = cond_matters | !insn[22];
			def_regs = idxbit(rd);
		end
		issue_pkg::class_msr:
		begin
			use_regs = idxbit(rm);
			def_cpsr = 1'b1;
		end
		issue_pkg::class_msr_flags:
		begin
			use_regs = insn[25] ? 16'h0 : idxbit(rm);
			def_cpsr = 1'b1;
		end
		issue_pkg::class_swp:
		begin
			use_regs = idxbit(rn) | idxbit(rm);
			def_regs = idxbit(rd);
		end
		issue_pkg::class_bx:
		begin
			use_regs = idxbit(rm);
		end
		issue_pkg::class_hdata_reg:
		begin
			use_regs = idxbit(rn) | idxbit(rm) | (load ? 16'h0 : idxbit(rd));
			def_regs = (load ? idxbit(rd) : 16'h0) | (write_back ? idxbit(rn) : 16'h0);
		end
		issue_pkg::class_hdata_imm:
		begin
			use_regs = idxbit(rn) | (load ? 16'h0 : idxbit(rd));
			def_regs = (load ? idxbit(rd) : 16'h0) | (write_back ? idxbit(rn) : 16'h0);
		end
		issue_pkg::class_alu:
		begin
			use_cpsr = cond_matters | (!insn[25] && shift_uses_carry);
			if (!insn[25])
				use_regs = idxbit(rm) | (insn[4] ? idxbit(rs) : 16'h0);
			// mov and mvn have no first operand.
			if ((alu_op != issue_pkg::alu_mov) && (alu_op != issue_pkg::alu_mvn))
				use_regs = use_regs | idxbit(rn);
			def_cpsr = insn[20];
			if (!(alu_op inside {issue_pkg::alu_tst, issue_pkg::alu_teq,
				issue_pkg::alu_cmp, issue_pkg::alu_cmn}))
				def_regs = idxbit(rd);
		end
		issue_pkg::class_ldrstr:
		begin
			// register offset when the I bit is set.
			use_regs = idxbit(rn) | (insn[25] ? idxbit(rm) : 16'h0) |
				(load ? 16'h0 : idxbit(rd));
			def_regs = (load ? idxbit(rd) : 16'h0) | (write_back ? idxbit(rn) : 16'h0);
		end
		issue_pkg::class_ldmstm:
		begin
			use_regs = idxbit(rn) | (load ? 16'h0 : reg_list);
			// the S bit may touch the CPSR on a load with the pc, so assume it always does.
			def_cpsr = insn[22];
			def_regs = (insn[21] ? idxbit(rn) : 16'h0) | (load ? reg_list : 16'h0);
		end
		issue_pkg::class_ldcstc:
		begin
			use_regs = idxbit(rn);
			def_regs = insn[21] ? idxbit(rn) : 16'h0;
		end
		issue_pkg::class_mrcmcr:
		begin
			use_regs = load ? 16'h0 : idxbit(rd);
			def_regs = load ? idxbit(rd) : 16'h0;
		end
		issue_pkg::class_ldrstr_undef, issue_pkg::class_unknown:
		begin
			// undefined encodings go through with no dependencies at all.
			use_cpsr = 1'b0;
		end
		default:
		begin
			// branch, cdp and swi only depend on their condition.
			use_regs = 16'h0;
		end
		endcase
	end

endmodule

// File: verification/issue_stage_checker.sv
`timescale 1ns/1ps

module issue_stage_checker (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        outstall,
	input  logic        outbubble,
	input  logic [31:0] outpc,
	input  logic [31:0] outinsn,
	input  logic        exp_outstall,
	input  logic        exp_outbubble,
	input  logic [31:0] exp_outpc,
	input  logic [31:0] exp_outinsn,
	output int          error_count,
	output int          check_count
);

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
		end
	endtask

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	// inputs and registers move on the rising edge, so the falling edge sees them settled.
	// the registered outputs are checked every cycle, which also covers the hold under stall.
	always @(negedge clk)
	begin
		if (arst_n)
		begin
			compare("outstall", {31'h0, exp_outstall}, {31'h0, outstall});
			compare("outbubble", {31'h0, exp_outbubble}, {31'h0, outbubble});
			compare("outpc", exp_outpc, outpc);
			compare("outinsn", exp_outinsn, outinsn);
		end
	end

endmodule

// File: verification/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

	// the stimulus below takes roughly 600 cycles.
	localparam int stim_cycles = 600;
	localparam int max_cycles  = 3 * stim_cycles + 200;

	logic        clk;
	logic        arst_n;
	logic        stall;
	logic        flush;
	logic        inbubble;
	logic [31:0] insn;
	logic [31:0] inpc;
	logic [31:0] cpsr;
	logic        outstall;
	logic        outbubble;
	logic [31:0] outpc;
	logic [31:0] outinsn;

	logic [31:0] lfsr;
	logic [31:0] pc_count;
	int          cycles;
	int          error_count;
	int          check_count;

	// model scoreboard, slot 0 is execute and the last slot is memory.
	logic [issue_pkg::inflight_slots-1:0][15:0] m_regs;
	logic [issue_pkg::inflight_slots-1:0]       m_cpsr;
	logic [15:0] busy_regs;
	logic        busy_cpsr;
	logic [34:0] usage;
	logic        exp_waiting;
	logic        exp_issuing;
	logic        exp_outstall;
	logic        exp_outbubble;
	logic [31:0] exp_outpc;
	logic [31:0] exp_outinsn;

	issue_stage i_issue_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.stall     (stall),
		.flush     (flush),
		.inbubble  (inbubble),
		.insn      (insn),
		.inpc      (inpc),
		.cpsr      (cpsr),
		.outstall  (outstall),
		.outbubble (outbubble),
		.outpc     (outpc),
		.outinsn   (outinsn)
	);

	issue_stage_checker u_checker (
		.clk           (clk),
		.arst_n        (arst_n),
		.outstall      (outstall),
		.outbubble     (outbubble),
		.outpc         (outpc),
		.outinsn       (outinsn),
		.exp_outstall  (exp_outstall),
		.exp_outbubble (exp_outbubble),
		.exp_outpc     (exp_outpc),
		.exp_outinsn   (exp_outinsn),
		.error_count   (error_count),
		.check_count   (check_count)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = 32'h0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] reg_bit(input logic [3:0] r);
		if (r == issue_pkg::pc_reg)
			return 16'h0;
		return 16'h1 << r;
	endfunction

	// conditions come in pairs, the odd code of each pair is the inverse of the even one.
	function automatic logic cond_holds(input logic [3:0] code, input logic [31:0] psr);
		logic n;
		logic z;
		logic c;
		logic v;
		logic base;
		n = psr[issue_pkg::cpsr_n];
		z = psr[issue_pkg::cpsr_z];
		c = psr[issue_pkg::cpsr_c];
		v = psr[issue_pkg::cpsr_v];
		case (issue_pkg::cond_e'({code[3:1], 1'b0}))
		issue_pkg::cond_eq: base = z;
		issue_pkg::cond_cs: base = c;
		issue_pkg::cond_mi: base = n;
		issue_pkg::cond_vs: base = v;
		issue_pkg::cond_hi: base = c & ~z;
		issue_pkg::cond_ge: base = (n == v);
		issue_pkg::cond_gt: base = ~z & (n == v);
		default:            base = 1'b1;
		endcase
		return base ^ code[0];
	endfunction

	// returns {condition passes, read mask, reads cpsr, write mask, writes cpsr}.
	function automatic logic [34:0] ref_issue(input logic [31:0] w, input logic [31:0] psr);
		issue_pkg::alu_op_e op;
		logic [15:0] use_r;
		logic [15:0] def_r;
		logic [15:0] list;
		logic        use_c;
		logic        def_c;
		logic        carry_shift;
		op = issue_pkg::alu_op_e'(w[24:21]);
		use_r = 16'h0;
		def_r = 16'h0;
		def_c = 1'b0;
		list = w[15:0];
		list[issue_pkg::pc_reg] = 1'b0;
		use_c = (w[31:28] != issue_pkg::cond_al);
		carry_shift = !w[25] && !w[4] && (w[11:7] == 5'd0) &&
			((w[6:5] == issue_pkg::shift_lsl) || (w[6:5] == issue_pkg::shift_ror));
		if ((w[27:22] == 6'd0) && (w[7:4] == 4'b1001))
		begin
			// multiply keeps rd in 19:16 and the accumulator in 15:12.
			use_r = reg_bit(w[11:8]) | reg_bit(w[3:0]) | (w[21] ? reg_bit(w[15:12]) : 16'h0);
			def_r = reg_bit(w[19:16]);
			def_c = w[20];
		end
		else if ((w[27:23] == 5'b00010) && (w[21:16] == 6'h0f) && (w[11:0] == 12'h0))
		begin
			use_c = use_c | !w[22];
			def_r = reg_bit(w[15:12]);
		end
		else if ((w[27:23] == 5'b00010) && (w[21:4] == 18'h29f00))
		begin
			use_r = reg_bit(w[3:0]);
			def_c = 1'b1;
		end
		else if (w[27:26] == 2'b00)
		begin
			if (!w[25])
				use_r = reg_bit(w[3:0]) | (w[4] ? reg_bit(w[11:8]) : 16'h0);
			if ((op != issue_pkg::alu_mov) && (op != issue_pkg::alu_mvn))
				use_r = use_r | reg_bit(w[19:16]);
			if ((op < issue_pkg::alu_tst) || (op > issue_pkg::alu_cmn))
				def_r = reg_bit(w[15:12]);
			def_c = w[20];
			use_c = use_c | carry_shift;
		end
		else if (w[27:26] == 2'b01)
		begin
			use_r = reg_bit(w[19:16]) | (w[25] ? reg_bit(w[3:0]) : 16'h0) |
				(w[20] ? 16'h0 : reg_bit(w[15:12]));
			def_r = (w[20] ? reg_bit(w[15:12]) : 16'h0) |
				((w[21] || !w[24]) ? reg_bit(w[19:16]) : 16'h0);
		end
		else if (w[27:25] == 3'b100)
		begin
			use_r = reg_bit(w[19:16]) | (w[20] ? 16'h0 : list);
			def_r = (w[21] ? reg_bit(w[19:16]) : 16'h0) | (w[20] ? list : 16'h0);
			def_c = w[22];
		end
		return {cond_holds(w[31:28], psr), use_r, use_c, def_r, def_c};
	endfunction

	function automatic logic [31:0] alu_reg(input logic [3:0] cnd, input logic [3:0] op,
		input logic s, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm,
		input logic [4:0] shamt, input logic [1:0] sh);
		return {cnd, 3'b000, op, s, rn, rd, shamt, sh, 1'b0, rm};
	endfunction

	function automatic logic [31:0] alu_imm(input logic [3:0] cnd, input logic [3:0] op,
		input logic s, input logic [3:0] rd, input logic [3:0] rn);
		return {cnd, 3'b001, op, s, rn, rd, 12'h05a};
	endfunction

	function automatic logic [31:0] ldr_str(input logic [3:0] cnd, input logic l,
		input logic wb, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm,
		input logic reg_off);
		return {cnd, 2'b01, reg_off, 3'b110, wb, l, rn, rd,
			reg_off ? {5'd2, 3'b000, rm} : 12'h004};
	endfunction

	function automatic logic [31:0] ldm_stm(input logic [3:0] cnd, input logic l,
		input logic s, input logic wb, input logic [3:0] rn, input logic [15:0] list);
		return {cnd, 3'b100, 2'b01, s, wb, l, rn, list};
	endfunction

	function automatic logic [31:0] mul_acc(input logic [3:0] cnd, input logic a,
		input logic s, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rs,
		input logic [3:0] rm);
		return {cnd, 6'b000000, a, s, rd, rn, rs, 4'b1001, rm};
	endfunction

	function automatic logic [31:0] mrs_cpsr(input logic [3:0] rd);
		return {issue_pkg::cond_al, 8'h10, 4'hf, rd, 12'h000};
	endfunction

	function automatic logic [31:0] msr_cpsr(input logic [3:0] rm);
		return {issue_pkg::cond_al, 8'h12, 4'h9, 4'hf, 8'h00, rm};
	endfunction

	// registers stay within r0 to r7 so that hazards come up often.
	function automatic logic [31:0] random_insn();
		logic [3:0] cnd;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rn;
		logic [3:0] rm;
		logic [3:0] rs;
		logic [4:0] shamt;
		logic [1:0] sh;
		logic [2:0] kind;
		logic       s;
		logic       l;
		logic       wb;
		cnd = (rand_bits(2) == 0) ? rand_bits(4) : issue_pkg::cond_al;
		op = rand_bits(4);
		s = rand_bits(1);
		// compares without S would land in the MRS and MSR encodings.
		s = s | (op[3:2] == 2'b10);
		l = rand_bits(1);
		wb = rand_bits(1);
		rd = rand_bits(3);
		rn = rand_bits(3);
		rm = rand_bits(3);
		rs = rand_bits(3);
		shamt = rand_bits(5);
		sh = rand_bits(2);
		kind = rand_bits(3);
		case (kind)
		3'd0: return alu_reg(cnd, op, s, rd, rn, rm, shamt, sh);
		3'd1: return {cnd, 3'b000, op, s, rn, rd, rs, 1'b0, sh, 1'b1, rm};
		3'd2: return alu_imm(cnd, op, s, rd, rn);
		3'd3: return ldr_str(cnd, l, wb, rd, rn, rm, s);
		3'd4: return ldm_stm(cnd, l, s, wb, rn, {8'h00, shamt, sh, wb});
		3'd5: return mul_acc(cnd, wb, s, rd, rn, rs, rm);
		3'd6: return mrs_cpsr(rd);
		default: return l ? msr_cpsr(rm) : {cnd, 4'b1010, 24'h000010};
		endcase
	endfunction

	// drives one decode slot and waits until the stage takes it.
	task automatic present(input logic [31:0] word, input logic bub, input int stall_cycles,
		input logic kill);
		logic accepted;
		int   edges;
		insn <= word;
		inpc <= pc_count;
		inbubble <= bub;
		stall <= (stall_cycles > 0);
		flush <= kill;
		accepted = 1'b0;
		edges = 0;
		while (!accepted)
		begin
			@(negedge clk);
			accepted = !outstall;
			@(posedge clk);
			edges++;
			flush <= 1'b0;
			if (edges == stall_cycles)
				stall <= 1'b0;
		end
		pc_count = pc_count + 32'd4;
	endtask

	always_comb
	begin
		usage = ref_issue(insn, cpsr);
		busy_regs = 16'h0;
		busy_cpsr = 1'b0;
		for (int i = 0; i < issue_pkg::inflight_slots; i++)
		begin
			busy_regs = busy_regs | m_regs[i];
			busy_cpsr = busy_cpsr | m_cpsr[i];
		end
		exp_waiting = (|(usage[33:18] & busy_regs)) || (usage[17] && busy_cpsr);
		exp_issuing = !inbubble && !exp_waiting && usage[34];
		exp_outstall = stall || (exp_waiting && !inbubble);
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			m_regs <= '0;
			m_cpsr <= '0;
			exp_outbubble <= 1'b1;
			exp_outpc <= 32'h0;
			exp_outinsn <= 32'h0;
		end
		else if (flush)
		begin
			m_regs <= '0;
			m_cpsr <= '0;
			exp_outbubble <= 1'b1;
		end
		else if (!stall)
		begin
			m_regs <= {m_regs[issue_pkg::inflight_slots-2:0], exp_issuing ? usage[16:1] : 16'h0};
			m_cpsr <= {m_cpsr[issue_pkg::inflight_slots-2:0], exp_issuing && usage[0]};
			exp_outbubble <= inbubble || exp_waiting || !usage[34];
			exp_outpc <= inpc;
			exp_outinsn <= insn;
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial
	begin : stimulus
		logic [3:0]  cnd;
		logic [3:0]  t;
		logic [31:0] word;
		logic [31:0] reader;
		logic        bub;
		int          hold;
		clk = 1'b0;
		arst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		inbubble = 1'b1;
		insn = 32'h0;
		inpc = 32'h0;
		cpsr = 32'h0;
		cycles = 0;
		lfsr = 32'h720f_3b47;
		pc_count = 32'h0000_8000;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < 8; i++)
			present(alu_imm(issue_pkg::cond_al, issue_pkg::alu_mov, 1'b0, i, 4'd0), 0, 0, 0);

		// read after write one and two instructions back.
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 0, 1, 2, 3, 1, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 0, 4, 1, 5, 1, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_sub, 0, 6, 2, 3, 1, 0), 0, 0, 0);
		present(alu_imm(issue_pkg::cond_al, issue_pkg::alu_mov, 0, 7, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_orr, 0, 8, 6, 0, 1, 0), 0, 0, 0);
		present(32'h0, 1, 0, 0);

		// flag writers followed by a conditional, an rrx and a plain reader.
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 1, 1, 2, 3, 1, 0), 0, 0, 0);
		present(alu_imm(issue_pkg::cond_eq, issue_pkg::alu_mov, 0, 9, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 1, 1, 2, 3, 1, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_mov, 0, 10, 0, 2, 0, 3), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 1, 1, 2, 3, 1, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_mov, 0, 11, 0, 2, 3, 0), 0, 0, 0);

		// random flags against random conditions, each followed by a reader of its target.
		for (int i = 0; i < 32; i++)
		begin
			cpsr <= {rand_bits(4), 28'h0};
			cnd = rand_bits(4);
			present(alu_imm(cnd, issue_pkg::alu_mov, 0, 3, 0), 0, 0, 0);
			present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 0, 4, 3, 3, 1, 0), 0, 0, 0);
		end

		// downstream stall on a waiting reader and on an independent one.
		present(ldr_str(issue_pkg::cond_al, 1, 0, 5, 6, 0, 0), 0, 0, 0);
		present(alu_reg(issue_pkg::cond_al, issue_pkg::alu_add, 0, 7, 5, 1, 1, 0), 0, 4, 0);
		present(alu_imm(issue_pkg::cond_al, issue_pkg::alu_mov, 0, 2, 0), 0, 3, 0);

		// flush while a reader waits on a load, block transfer, multiply or status move.
		for (int i = 0; i < 16; i++)
		begin
			t = rand_bits(3);
			case (rand_bits(2))
			2'd0: word = ldr_str(issue_pkg::cond_al, 1, rand_bits(1), t, t ^ 4'd1, 0, 0);
			2'd1: word = ldm_stm(issue_pkg::cond_al, rand_bits(1), 0, 1, t, 16'h00c0);
			2'd2: word = mul_acc(issue_pkg::cond_al, 0, 0, t, 0, 1, 2);
			default: word = rand_bits(1) ? mrs_cpsr(t) : msr_cpsr(4'd1);
			endcase
			reader = alu_reg(issue_pkg::cond_ne, issue_pkg::alu_add, 0, 7, t, t, 1, 0);
			present(word, 0, 0, 0);
			present(reader, 0, 0, 1);
		end

		// mixed random stream with bubbles, stalls and flag changes.
		for (int i = 0; i < 150; i++)
		begin
			if (rand_bits(3) == 0)
				cpsr <= {rand_bits(4), 28'h0};
			word = random_insn();
			bub = (rand_bits(3) == 0);
			hold = (rand_bits(3) == 0) ? rand_bits(2) : 0;
			present(word, bub, hold, 0);
		end

		present(32'h0, 1, 0, 0);
		repeat (3) @(negedge clk);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
